// File: dino_pkg.sv
/* Shared constants and types for the endless-runner game.
   Imported by the game, video and testbench modules. */
package dino_pkg;

    // 1280x480 video timing, in clocks and lines
    localparam int H_ACTIVE = 1280;
    localparam int H_FRONT  = 32;
    localparam int H_SYNC   = 192;
    localparam int H_BACK   = 96;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [10:0] xpos_t;

    // Object placement
    localparam int DINO_X   = 100;
    localparam int GROUND_Y = 248;
    localparam int PTERO_Y  = 200;
    localparam int OBJ_SIZE = 32;
    localparam int GROUP_W  = 64;

    localparam xpos_t CACTUS_START = 11'd1200;
    localparam xpos_t GROUP_START  = 11'd1600;
    localparam xpos_t LAVA_START   = 11'd1800;
    localparam xpos_t PTERO_START  = 11'd1400;

    localparam int SCORE_X     = 120;
    localparam int SCORE_Y     = 10;
    localparam int DIGIT_PITCH = 16;

    localparam int REPLAY_BIT = 4;

    // Colours as 24-bit RGB
    localparam logic [23:0] SKY_RGB    = 24'h87CEEB;
    localparam logic [23:0] DINO_RGB   = 24'h535353;
    localparam logic [23:0] CACTUS_RGB = 24'h2E8B57;
    localparam logic [23:0] LAVA_RGB   = 24'hFF4500;
    localparam logic [23:0] PTERO_RGB  = 24'h8B4513;
    localparam logic [23:0] TEXT_RGB   = 24'h000000;

    typedef enum logic {
        PLAY_RUNNING,
        PLAY_OVER
    } play_state_e;

    typedef logic [3:0] bcd_digit_t;
    // Digit 0 is the units digit
    typedef bcd_digit_t [4:0] score_bcd_t;

endpackage

// File: game_if.sv
/* Game signals shared between the input stage, the game logic and the video side.
   The controller drives tick and replay; the obstacle field drives state and positions. */
`timescale 1ns/1ps

interface game_if;
    import dino_pkg::*;

    logic        tick;
    logic        replay;
    play_state_e state;
    xpos_t       cactus_x;
    xpos_t       group_x;
    xpos_t       lava_x;
    xpos_t       ptero_x;

    modport source (output tick, output replay);

    modport game (input tick, input replay,
                  output state, output cactus_x, output group_x, output lava_x, output ptero_x);

    modport view (input tick, input state,
                  input cactus_x, input group_x, input lava_x, input ptero_x);

endinterface

// File: controller_input.sv
/* Brings the controller report into the clock domain and makes the motion tick. */
`timescale 1ns/1ps

module controller_input #(
    parameter int TICK_CYCLES = 2_000_000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] controller_report,
    game_if.source     bus
);
    import dino_pkg::*;

    logic [1:0]                       replay_sync;
    logic [$clog2(TICK_CYCLES)-1:0]   tick_cnt;

    // Only the replay button matters, so only that bit is synchronised
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            replay_sync <= '0;
        end else begin
            replay_sync <= {replay_sync[0], controller_report[REPLAY_BIT]};
        end
    end

    assign bus.replay = replay_sync[1];

    // Tick fires on the last count of each period
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
            bus.tick <= 1'b0;
        end else if (int'(tick_cnt) == TICK_CYCLES - 1) begin
            tick_cnt <= '0;
            bus.tick <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            bus.tick <= 1'b0;
        end
    end

    tick_is_pulse: assert property (@(posedge clk) disable iff (reset) bus.tick |=> !bus.tick)
        else $error("motion tick high on two consecutive clocks");

endmodule

// File: obstacle_field.sv
/* Moves the four obstacles, tests them against the dino box and runs the play state.
   Replay during game over puts the obstacles back at their start positions. */
`timescale 1ns/1ps

module obstacle_field (
    input  logic clk,
    input  logic reset,
    game_if.game bus
);
    import dino_pkg::*;

    logic hit;

    // One pixel to the left, parked at the screen edge
    function automatic xpos_t step_left(input xpos_t x);
        return (x == '0) ? '0 : x - 1'b1;
    endfunction

    // Box overlap against the dino, which sits at (DINO_X, GROUND_Y)
    function automatic logic hits_dino(input xpos_t ox, input int oy, input int ow);
        return (DINO_X < int'(ox) + ow) && (DINO_X + OBJ_SIZE > int'(ox)) &&
               (GROUND_Y < oy + OBJ_SIZE) && (GROUND_Y + OBJ_SIZE > oy);
    endfunction

    always_comb begin
        hit = hits_dino(bus.cactus_x, GROUND_Y, OBJ_SIZE) ||
              hits_dino(bus.group_x, GROUND_Y, GROUP_W) ||
              hits_dino(bus.lava_x, GROUND_Y, OBJ_SIZE) ||
              hits_dino(bus.ptero_x, PTERO_Y, OBJ_SIZE);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bus.state    <= PLAY_RUNNING;
            bus.cactus_x <= CACTUS_START;
            bus.group_x  <= GROUP_START;
            bus.lava_x   <= LAVA_START;
            bus.ptero_x  <= PTERO_START;
        end else begin
            case (bus.state)
                PLAY_RUNNING: begin
                    if (hit) begin
                        bus.state <= PLAY_OVER;
                    end
                    if (bus.tick) begin
                        bus.cactus_x <= step_left(bus.cactus_x);
                        bus.group_x  <= step_left(bus.group_x);
                        bus.lava_x   <= step_left(bus.lava_x);
                        bus.ptero_x  <= step_left(bus.ptero_x);
                    end
                end
                PLAY_OVER: begin
                    // Positions freeze until the player asks for another round
                    if (bus.replay) begin
                        bus.state    <= PLAY_RUNNING;
                        bus.cactus_x <= CACTUS_START;
                        bus.group_x  <= GROUP_START;
                        bus.lava_x   <= LAVA_START;
                        bus.ptero_x  <= PTERO_START;
                    end
                end
            endcase
        end
    end

    frozen_when_over: assert property (
        @(posedge clk) disable iff (reset)
        (bus.state == PLAY_OVER && !bus.replay) |=>
            $stable({bus.cactus_x, bus.group_x, bus.lava_x, bus.ptero_x})
    ) else $error("obstacle moved during game over");

endmodule

// File: score_counter.sv
/* Five-digit BCD score, one count per motion tick while the game runs.
   Wraps from 99999 to 0 and survives a replay. */
`timescale 1ns/1ps

module score_counter (
    input  logic                 clk,
    input  logic                 reset,
    game_if.view                 bus,
    output dino_pkg::score_bcd_t score
);
    import dino_pkg::*;

    score_bcd_t score_next;

    // Ripple carry through the digits, units first
    always_comb begin
        logic carry;
        carry = 1'b1;
        score_next = score;
        for (int i = 0; i < 5; i++) begin
            if (carry) begin
                if (score[i] == 4'd9) begin
                    score_next[i] = '0;
                end else begin
                    score_next[i] = score[i] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score <= '0;
        end else if (bus.tick && bus.state == PLAY_RUNNING) begin
            score <= score_next;
        end
    end

    for (genvar i = 0; i < 5; i++) begin : g_digit_chk
        digit_is_bcd: assert property (@(posedge clk) disable iff (reset) score[i] <= 4'd9)
            else $error("score digit %0d left the BCD range", i);
    end

endmodule

// File: vga_timing.sv
/* Horizontal and vertical counters for the 1280x480 frame.
   Sync, blank and the pixel clock are decoded from the counter values. */
`timescale 1ns/1ps

module vga_timing (
    input  logic              clk,
    input  logic              reset,
    output dino_pkg::hcount_t hcount,
    output dino_pkg::vcount_t vcount,
    output logic              vga_clk,
    output logic              hsync,
    output logic              vsync,
    output logic              blank_n,
    output logic              sync_n
);
    import dino_pkg::*;

    logic end_of_line;
    logic end_of_field;

    assign end_of_line  = (int'(hcount) == H_TOTAL - 1);
    assign end_of_field = (int'(vcount) == V_TOTAL - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            hcount <= end_of_line ? '0 : hcount + 1'b1;
            if (end_of_line) begin
                vcount <= end_of_field ? '0 : vcount + 1'b1;
            end
        end
    end

    // Syncs are active low inside their pulse windows
    assign hsync = !((int'(hcount) >= H_ACTIVE + H_FRONT) &&
                     (int'(hcount) < H_ACTIVE + H_FRONT + H_SYNC));
    assign vsync = !((int'(vcount) >= V_ACTIVE + V_FRONT) &&
                     (int'(vcount) < V_ACTIVE + V_FRONT + V_SYNC));

    assign blank_n = (int'(hcount) < H_ACTIVE) && (int'(vcount) < V_ACTIVE);
    assign sync_n  = 1'b0;
    assign vga_clk = hcount[0];

endmodule

// File: pixel_renderer.sv
/* Picks the colour of each pixel from the sky, the score text and the object boxes.
   The result is registered, so it trails hcount by one clock. */
`timescale 1ns/1ps

module pixel_renderer (
    input  logic                 clk,
    input  logic                 reset,
    input  dino_pkg::hcount_t    hcount,
    input  dino_pkg::vcount_t    vcount,
    input  dino_pkg::score_bcd_t score,
    game_if.view                 bus,
    output logic [7:0]           red,
    output logic [7:0]           green,
    output logic [7:0]           blue
);
    import dino_pkg::*;

    logic        text_on;
    logic [23:0] colour;
    logic [23:0] rgb_q;

    // 8x8 digit glyphs, top row in the high byte, leftmost pixel in the MSB
    function automatic logic font_pixel(input bcd_digit_t d, input int row, input int col);
        logic [63:0] glyph;
        case (d)
            4'd0: glyph = 64'h3C666E7E76663C00;
            4'd1: glyph = 64'h1838181818187E00;
            4'd2: glyph = 64'h3C66061C30667E00;
            4'd3: glyph = 64'h3C66061C06663C00;
            4'd4: glyph = 64'h0C1C2C4C7E0C0C00;
            4'd5: glyph = 64'h7E607C0606663C00;
            4'd6: glyph = 64'h3C66607C66663C00;
            4'd7: glyph = 64'h7E060C1830303000;
            4'd8: glyph = 64'h3C66663C66663C00;
            4'd9: glyph = 64'h3C66663E06663C00;
            default: glyph = '0;
        endcase
        return glyph[63 - 8 * row - col];
    endfunction

    function automatic logic in_box(input int px, input int py, input int x, input int y,
                                    input int w, input int h);
        return (px >= x) && (px < x + w) && (py >= y) && (py < y + h);
    endfunction

    // Most significant digit sits leftmost
    always_comb begin
        int dx;
        int dy;
        text_on = 1'b0;
        dy = int'(vcount) - SCORE_Y;
        for (int i = 0; i < 5; i++) begin
            dx = int'(hcount) - (SCORE_X + (4 - i) * DIGIT_PITCH);
            if (dx >= 0 && dx < 8 && dy >= 0 && dy < 8 && font_pixel(score[i], dy, dx)) begin
                text_on = 1'b1;
            end
        end
    end

    // Later boxes paint over earlier ones
    always_comb begin
        int px;
        int py;
        px = int'(hcount);
        py = int'(vcount);
        colour = SKY_RGB;
        if (text_on) begin
            colour = TEXT_RGB;
        end
        if (bus.state == PLAY_RUNNING) begin
            if (in_box(px, py, DINO_X, GROUND_Y, OBJ_SIZE, OBJ_SIZE)) begin
                colour = DINO_RGB;
            end
            if (in_box(px, py, int'(bus.cactus_x), GROUND_Y, OBJ_SIZE, OBJ_SIZE)) begin
                colour = CACTUS_RGB;
            end
            if (in_box(px, py, int'(bus.group_x), GROUND_Y, GROUP_W, OBJ_SIZE)) begin
                colour = CACTUS_RGB;
            end
            if (in_box(px, py, int'(bus.lava_x), GROUND_Y, OBJ_SIZE, OBJ_SIZE)) begin
                colour = LAVA_RGB;
            end
            if (in_box(px, py, int'(bus.ptero_x), PTERO_Y, OBJ_SIZE, OBJ_SIZE)) begin
                colour = PTERO_RGB;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rgb_q <= SKY_RGB;
        end else begin
            rgb_q <= colour;
        end
    end

    assign {red, green, blue} = rgb_q;

endmodule

// File: dino_run_top.sv
/* Top level of the runner game: controller input, game logic and VGA output.
   game_over and score_bcd feed the board LEDs and hex displays. */
`timescale 1ns/1ps

module dino_run_top #(
    parameter int TICK_CYCLES = 2_000_000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  controller_report,
    output logic [7:0]  VGA_R,
    output logic [7:0]  VGA_G,
    output logic [7:0]  VGA_B,
    output logic        VGA_CLK,
    output logic        VGA_HS,
    output logic        VGA_VS,
    output logic        VGA_BLANK_n,
    output logic        VGA_SYNC_n,
    output logic        game_over,
    output logic [19:0] score_bcd
);
    import dino_pkg::*;

    hcount_t    hcount;
    vcount_t    vcount;
    score_bcd_t score;

    game_if gbus ();

    controller_input #(.TICK_CYCLES(TICK_CYCLES)) i_controller_input (
        .clk(clk), .reset(reset), .controller_report(controller_report), .bus(gbus)
    );

    obstacle_field i_obstacle_field (.clk(clk), .reset(reset), .bus(gbus));

    score_counter i_score_counter (.clk(clk), .reset(reset), .bus(gbus), .score(score));

    vga_timing i_vga_timing (
        .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount), .vga_clk(VGA_CLK),
        .hsync(VGA_HS), .vsync(VGA_VS), .blank_n(VGA_BLANK_n), .sync_n(VGA_SYNC_n)
    );

    pixel_renderer i_pixel_renderer (
        .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount), .score(score),
        .bus(gbus), .red(VGA_R), .green(VGA_G), .blue(VGA_B)
    );

    assign game_over = (gbus.state == PLAY_OVER);
    assign score_bcd = score;

endmodule

// File: tb_dino_run.sv
/* Self-checking testbench for the runner game top level.
   Check kinds and expected values come from dino_cases.txt, one check per line. */
`timescale 1ns/1ps

module tb_dino_run;
    import dino_pkg::*;

    localparam int TICKS       = 4;
    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    // Upper bound for one game, in clocks
    localparam int GAME_CLOCKS = 4500 * TICKS;
    localparam int WATCHDOG_CLOCKS = 2 * GAME_CLOCKS + 2 * H_TOTAL + 1000;

    logic        clk;
    logic        reset;
    logic [7:0]  controller_report;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic        vga_sync_n;
    logic        game_over;
    logic [19:0] score_bcd;

    int check_count = 0;
    int error_count = 0;

    dino_run_top #(.TICK_CYCLES(TICKS)) i_dino_run_top (
        .clk(clk), .reset(reset), .controller_report(controller_report),
        .VGA_R(vga_r), .VGA_G(vga_g), .VGA_B(vga_b), .VGA_CLK(vga_clk),
        .VGA_HS(vga_hs), .VGA_VS(vga_vs), .VGA_BLANK_n(vga_blank_n),
        .VGA_SYNC_n(vga_sync_n), .game_over(game_over), .score_bcd(score_bcd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CLOCKS * CLK_PERIOD);
        $display("Watchdog expired: the run took longer than the tests allow");
        $display("Test failures found");
        $finish;
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic note_failure(input string what);
        error_count++;
        $display("%s", what);
    endtask

    task automatic check_reset(input int over, input logic [31:0] score, input int hs,
                               input int vs, input int sync);
        check(game_over, over, "game_over after reset");
        check(score_bcd, score, "score_bcd after reset");
        check(vga_hs, hs, "VGA_HS after reset");
        check(vga_vs, vs, "VGA_VS after reset");
        check(vga_sync_n, sync, "VGA_SYNC_n after reset");
    endtask

    task automatic wait_hs_fall(output bit found);
        logic prev;
        found = 1'b0;
        prev = vga_hs;
        for (int i = 0; i < 2 * H_TOTAL && !found; i++) begin
            @(negedge clk);
            found = prev && !vga_hs;
            prev = vga_hs;
        end
    endtask

    // Counts from one HS falling edge up to the next
    task automatic measure_line(input int exp_period, input int exp_low, input int exp_blank);
        bit   found;
        logic prev;
        int   period;
        int   low;
        int   blank;
        wait_hs_fall(found);
        if (!found) begin
            note_failure("VGA_HS never fell within two lines");
        end else begin
            period = 0;
            low = 0;
            blank = 0;
            prev = vga_hs;
            found = 1'b0;
            while (!found && period < 2 * H_TOTAL) begin
                if (!vga_hs) begin
                    low++;
                end
                if (vga_blank_n) begin
                    blank++;
                end
                @(negedge clk);
                period++;
                found = prev && !vga_hs;
                prev = vga_hs;
            end
            check(period, exp_period, "clocks between HS falling edges");
            check(low, exp_low, "clocks with HS low");
            check(blank, exp_blank, "clocks with BLANK_n high");
        end
    endtask

    // Column 0 of the next line, one clock after blank_n rises
    task automatic check_sky(input int r, input int g, input int b);
        bit   found;
        logic prev;
        found = 1'b0;
        prev = vga_blank_n;
        for (int i = 0; i < 2 * H_TOTAL && !found; i++) begin
            @(negedge clk);
            found = !prev && vga_blank_n;
            prev = vga_blank_n;
        end
        if (!found) begin
            note_failure("VGA_BLANK_n never rose within two lines");
        end else begin
            // Pixel clock is the low bit of the column count
            check(vga_clk, 0, "VGA_CLK at column 0");
            @(negedge clk);
            check(vga_clk, 1, "VGA_CLK at column 1");
            check(game_over, 0, "game_over during sky check");
            check(vga_r, r, "red at column 0");
            check(vga_g, g, "green at column 0");
            check(vga_b, b, "blue at column 0");
        end
    endtask

    task automatic await_game_over(input logic [31:0] exp_score);
        int waited;
        waited = 0;
        while (!game_over && waited < GAME_CLOCKS) begin
            @(negedge clk);
            waited++;
        end
        if (!game_over) begin
            note_failure("game_over did not rise within 4500 motion ticks");
        end else begin
            check(score_bcd, exp_score, "score_bcd when game_over rose");
        end
    endtask

    task automatic hold_over(input int periods, input logic [31:0] exp_score, input int over);
        repeat (periods * TICKS) @(negedge clk);
        check(score_bcd, exp_score, "score_bcd during game over");
        check(game_over, over, "game_over while replay is low");
    endtask

    task automatic press_replay(input int max_clocks);
        int waited;
        @(posedge clk);
        #DRIVE_DELAY;
        controller_report[REPLAY_BIT] = 1'b1;
        waited = 0;
        // Each pass covers one rising edge that samples the button
        while (game_over && waited < max_clocks) begin
            @(posedge clk);
            @(negedge clk);
            waited++;
        end
        check(game_over, 0, "game_over after holding replay");
        @(posedge clk);
        #DRIVE_DELAY;
        controller_report[REPLAY_BIT] = 1'b0;
    endtask

    task automatic apply_case(input string line);
        string       kind;
        int          a;
        int          b;
        int          c;
        int          d;
        logic [31:0] s;
        int          n;
        n = $sscanf(line, "%s", kind);
        if (n != 1) begin
            note_failure($sformatf("Case line without a check kind: %s", line));
        end else if (kind == "reset" &&
                     $sscanf(line, "%s %d %h %d %d %d", kind, a, s, b, c, d) == 6) begin
            check_reset(a, s, b, c, d);
        end else if (kind == "hline" && $sscanf(line, "%s %d %d %d", kind, a, b, c) == 4) begin
            measure_line(a, b, c);
        end else if (kind == "sky" && $sscanf(line, "%s %d %d %d", kind, a, b, c) == 4) begin
            check_sky(a, b, c);
        end else if (kind == "collide" && $sscanf(line, "%s %h", kind, s) == 2) begin
            await_game_over(s);
        end else if (kind == "hold" && $sscanf(line, "%s %d %h %d", kind, a, s, b) == 4) begin
            hold_over(a, s, b);
        end else if (kind == "replay" && $sscanf(line, "%s %d", kind, a) == 2) begin
            press_replay(a);
        end else begin
            note_failure($sformatf("Unknown or malformed case line: %s", line));
        end
    endtask

    initial begin
        int    fd;
        string line;
        reset = 1'b1;
        controller_report = '0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk);

        fd = $fopen("dino_cases.txt", "r");
        if (fd == 0) begin
            note_failure("Cannot open the case file dino_cases.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
                    apply_case(line);
                end
            end
            $fclose(fd);
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: dino_cases.txt
# Columns: check kind, then its expected values in decimal; scores are BCD digits in hex
# Lines starting with # are skipped
# reset: game_over score_bcd VGA_HS VGA_VS VGA_SYNC_n
reset 0 00000 1 1 0
# hline: clocks between HS falls, clocks HS low, clocks BLANK_n high
hline 1600 192 1280
# sky: red green blue at column 0
sky 135 206 235
# collide: score_bcd when game_over rises (cactus 1200 meets dino edge 132)
collide 01069
# hold: tick periods waited, score_bcd, game_over
hold 100 01069 1
# replay: clocks allowed for game_over to clear
replay 3
# second game, score carries over
collide 02138

// File: tb.f
dino_pkg.sv
game_if.sv
controller_input.sv
obstacle_field.sv
score_counter.sv
vga_timing.sv
pixel_renderer.sv
dino_run_top.sv
tb_dino_run.sv

// File: Bender.yml
package:
  name: dino_run

sources:
  - dino_pkg.sv
  - game_if.sv
  - controller_input.sv
  - obstacle_field.sv
  - score_counter.sv
  - vga_timing.sv
  - pixel_renderer.sv
  - dino_run_top.sv
  - target: test
    files:
      - tb_dino_run.sv
